// ==== logic/compute_reward.sv ====
`timescale 1ns/1ps

module compute_reward #(
	parameter logic [qrouting_pkg::word_width-1:0] node_id = 16'd3
) (
	input logic clock,
	input logic nrst,
	input logic start,
	input logic [qrouting_pkg::word_width-1:0] destination_id,
	input logic [qrouting_pkg::word_width-1:0] hop_value,
	output logic [qrouting_pkg::word_width-1:0] reward,
	output logic done
);
	import qrouting_pkg::*;

	logic [word_width:0] sum;
	logic [word_width-1:0] sum_q;
	logic is_dest_q;
	logic v1;
	logic v2;

	// extra bit holds the carry for saturation
	assign sum = {1'b0, hop_value} + {1'b0, hop_cost};

	always_ff @(posedge clock) begin
		if (!nrst) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			done <= 1'b0;
		end else begin
			v1 <= start;
			v2 <= v1;
			done <= v2;
		end
	end

	// stage one: destination compare and saturated cost
	// stage two: final select, held until the next round
	always_ff @(posedge clock) begin
		if (start) begin
			is_dest_q <= (destination_id == node_id);
			sum_q <= sum[word_width] ? '1 : sum[word_width-1:0];
		end
		if (v1) begin
			reward <= is_dest_q ? '0 : sum_q;
		end
	end

endmodule

// ==== logic/find_my_best.sv ====
`timescale 1ns/1ps

module find_my_best #(
	parameter logic [qrouting_pkg::word_width-1:0] cluster_id = 16'd1
) (
	input logic clock,
	input logic nrst,
	input logic start,
	output logic [qrouting_pkg::addr_width-1:0] mem_addr,
	input logic [qrouting_pkg::word_width-1:0] mem_rdata,
	output logic [$clog2(qrouting_pkg::max_neighbors)-1:0] best_index,
	output logic [qrouting_pkg::word_width-1:0] best_id,
	output logic [qrouting_pkg::word_width-1:0] best_value,
	output logic [qrouting_pkg::word_width-1:0] count,
	output logic done
);
	import qrouting_pkg::*;

	localparam int iw = $clog2(max_neighbors);

	localparam logic [1:0] s_idle = 2'd0;
	localparam logic [1:0] s_count = 2'd1;
	localparam logic [1:0] s_scan = 2'd2;
	localparam logic [1:0] s_id = 2'd3;

	logic [1:0] state;
	// read issue counter, cost then cluster for every entry
	logic [iw+1:0] step;
	logic [iw+1:0] ret_step;
	logic [iw-1:0] ret_idx;
	logic ret_cluster;
	logic [addr_width-1:0] issue_addr;
	logic [word_width-1:0] cost_q;
	logic in_found;
	logic [iw-1:0] in_idx;
	logic [iw-1:0] all_idx;
	logic [word_width-1:0] in_cost;
	logic [word_width-1:0] all_cost;
	logic in_hit;
	logic all_hit;
	logic last;
	logic nxt_in_found;
	logic [iw-1:0] nxt_in_idx;
	logic [iw-1:0] nxt_all_idx;
	logic [iw-1:0] win_idx;
	logic [word_width-1:0] nxt_in_cost;
	logic [word_width-1:0] nxt_all_cost;

	// the word arriving now was issued one step earlier
	assign ret_step = step - 1'b1;
	assign ret_idx = ret_step[iw:1];
	assign ret_cluster = ret_step[0];
	assign issue_addr = (step[0] ? cluster_base : q_value_base) + addr_width'(step[iw:1]);

	// strict compare keeps the lower index on a tie
	assign in_hit = ret_cluster && mem_rdata == cluster_id && (!in_found || cost_q < in_cost);
	assign all_hit = ret_cluster && (ret_idx == '0 || cost_q < all_cost);
	assign nxt_in_found = in_found || in_hit;
	assign nxt_in_idx = in_hit ? ret_idx : in_idx;
	assign nxt_in_cost = in_hit ? cost_q : in_cost;
	assign nxt_all_idx = all_hit ? ret_idx : all_idx;
	assign nxt_all_cost = all_hit ? cost_q : all_cost;
	assign win_idx = nxt_in_found ? nxt_in_idx : nxt_all_idx;
	assign last = ret_cluster && word_width'(ret_idx) == count - 1'b1;

	// the winner's ID read goes out in the same cycle as the last compare
	always_comb begin
		case (state)
			s_idle: mem_addr = neighbor_count_addr;
			s_scan: mem_addr = last ? neighbor_id_base + addr_width'(win_idx) : issue_addr;
			default: mem_addr = issue_addr;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= s_idle;
			step <= '0;
			in_found <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				s_idle: begin
					if (start) begin
						step <= '0;
						in_found <= 1'b0;
						state <= s_count;
					end
				end
				s_count: begin
					step <= step + 1'b1;
					state <= (mem_rdata == '0) ? s_id : s_scan;
				end
				s_scan: begin
					step <= step + 1'b1;
					in_found <= nxt_in_found;
					if (last) begin
						state <= s_id;
					end
				end
				default: begin
					done <= 1'b1;
					state <= s_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == s_count) begin
			count <= mem_rdata;
			best_index <= '0;
			best_value <= '0;
		end
		if (state == s_scan) begin
			if (!ret_cluster) begin
				cost_q <= mem_rdata;
			end
			in_idx <= nxt_in_idx;
			in_cost <= nxt_in_cost;
			all_idx <= nxt_all_idx;
			all_cost <= nxt_all_cost;
			if (last) begin
				best_index <= win_idx;
				best_value <= nxt_in_found ? nxt_in_cost : nxt_all_cost;
			end
		end
		if (state == s_id) begin
			best_id <= (count == '0) ? '0 : mem_rdata;
		end
	end

	a_best_in_table: assert property (@(posedge clock) disable iff (!nrst)
		done |-> word_width'(best_index) < count)
		else $error("find_my_best: index %0d outside table of %0d", best_index, count);

endmodule

// ==== logic/learn_costs.sv ====
`timescale 1ns/1ps

module learn_costs (
	input logic clock,
	input logic nrst,
	input logic start,
	input logic [qrouting_pkg::word_width-1:0] source_id,
	input logic [qrouting_pkg::word_width-1:0] battery_stat,
	input logic [qrouting_pkg::word_width-1:0] value,
	input logic [qrouting_pkg::word_width-1:0] cluster,
	output logic [qrouting_pkg::addr_width-1:0] mem_addr,
	output logic mem_we,
	output logic [qrouting_pkg::word_width-1:0] mem_wdata,
	input logic [qrouting_pkg::word_width-1:0] mem_rdata,
	output logic done
);
	import qrouting_pkg::*;

	localparam int cw = $clog2(max_neighbors + 1);

	localparam logic [3:0] s_idle = 4'd0;
	localparam logic [3:0] s_get_count = 4'd1;
	localparam logic [3:0] s_scan = 4'd2;
	localparam logic [3:0] s_cmp = 4'd3;
	localparam logic [3:0] s_wr_q = 4'd4;
	localparam logic [3:0] s_wr_batt = 4'd5;
	localparam logic [3:0] s_wr_cluster = 4'd6;
	localparam logic [3:0] s_wr_count = 4'd7;
	localparam logic [3:0] s_full = 4'd8;

	logic [3:0] state;
	logic table_valid;
	logic [cw-1:0] count_q;
	logic [cw-1:0] idx;
	logic append_q;
	logic at_end;
	logic full;

	assign at_end = (idx == count_q);
	assign full = (count_q >= cw'(max_neighbors));

	// last write of the round, or nothing to write on a full table
	assign done = (state == s_wr_cluster && !append_q) || state == s_wr_count
		|| state == s_full;

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= s_idle;
			table_valid <= 1'b0;
			count_q <= '0;
			idx <= '0;
			append_q <= 1'b0;
		end else begin
			case (state)
				s_idle: begin
					if (start) begin
						idx <= '0;
						if (!table_valid) begin
							// count word is zeroed in this cycle, no need to read it
							table_valid <= 1'b1;
							count_q <= '0;
							state <= s_scan;
						end else begin
							state <= s_get_count;
						end
					end
				end
				s_get_count: begin
					count_q <= mem_rdata[cw-1:0];
					state <= s_scan;
				end
				s_scan: begin
					if (at_end) begin
						append_q <= !full;
						state <= full ? s_full : s_wr_q;
					end else begin
						state <= s_cmp;
					end
				end
				s_cmp: begin
					if (mem_rdata == source_id) begin
						append_q <= 1'b0;
						state <= s_wr_q;
					end else begin
						idx <= idx + 1'b1;
						state <= s_scan;
					end
				end
				s_wr_q: state <= s_wr_batt;
				s_wr_batt: state <= s_wr_cluster;
				s_wr_cluster: state <= append_q ? s_wr_count : s_idle;
				default: state <= s_idle;
			endcase
		end
	end

	always_comb begin
		mem_addr = neighbor_count_addr;
		mem_we = 1'b0;
		mem_wdata = '0;
		case (state)
			s_idle: mem_we = start && !table_valid;
			s_scan: begin
				mem_addr = neighbor_id_base + addr_width'(idx);
				// unknown source, its ID takes the free slot right away
				if (at_end && !full) begin
					mem_we = 1'b1;
					mem_wdata = source_id;
				end
			end
			s_wr_q: begin
				mem_addr = q_value_base + addr_width'(idx);
				mem_we = 1'b1;
				mem_wdata = value;
			end
			s_wr_batt: begin
				mem_addr = battery_base + addr_width'(idx);
				mem_we = 1'b1;
				mem_wdata = battery_stat;
			end
			s_wr_cluster: begin
				mem_addr = cluster_base + addr_width'(idx);
				mem_we = 1'b1;
				mem_wdata = cluster;
			end
			s_wr_count: begin
				mem_we = 1'b1;
				mem_wdata = word_width'(count_q + 1'b1);
			end
			default: ;
		endcase
	end

	a_count_cap: assert property (@(posedge clock) disable iff (!nrst)
		(mem_we && mem_addr == neighbor_count_addr) |-> mem_wdata <= word_width'(max_neighbors))
		else $error("learn_costs: count %0d written past capacity", mem_wdata);

endmodule

// ==== logic/node_memory.sv ====
`timescale 1ns/1ps

module node_memory #(
	parameter int mem_depth = 256
) (
	input logic clock,
	input logic [qrouting_pkg::addr_width-1:0] addr,
	input logic we,
	input logic [qrouting_pkg::word_width-1:0] wdata,
	output logic [qrouting_pkg::word_width-1:0] rdata
);
	import qrouting_pkg::*;

	logic [word_width-1:0] mem [mem_depth];

	// single port, read data one cycle after the address
	// a read during a write returns the previous word
	always_ff @(posedge clock) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

	// the table map has to fit the chosen depth
	a_addr_in_range: assert property (@(posedge clock) we |-> int'(addr) < mem_depth)
		else $error("node_memory: write to %0h beyond depth %0d", addr, mem_depth);

endmodule

// ==== logic/qrouting_node.sv ====
`timescale 1ns/1ps

module qrouting_node #(
	parameter logic [qrouting_pkg::word_width-1:0] node_id = 16'd3,
	parameter logic [qrouting_pkg::word_width-1:0] cluster_id = 16'd1,
	parameter logic [3:0] initial_epsilon = 4'd6,
	parameter logic [3:0] epsilon_step = 4'd2,
	parameter int mem_depth = 256
) (
	input logic clock,
	input logic nrst,
	input logic report_valid,
	input logic [qrouting_pkg::word_width-1:0] f_source_id,
	input logic [qrouting_pkg::word_width-1:0] f_battery_stat,
	input logic [qrouting_pkg::word_width-1:0] f_value,
	input logic [qrouting_pkg::word_width-1:0] f_cluster_id,
	input logic [qrouting_pkg::word_width-1:0] f_destination_id,
	output logic busy,
	output logic [qrouting_pkg::word_width-1:0] next_hop,
	output logic explored,
	output logic [qrouting_pkg::word_width-1:0] reward_out,
	output logic done_reward
);
	import qrouting_pkg::*;

	stage_t stage;
	logic start_learn;
	logic start_best;
	logic start_policy;
	logic start_reward;
	logic done_learn;
	logic done_best;
	logic done_policy;

	// captured report
	logic [word_width-1:0] src_q;
	logic [word_width-1:0] batt_q;
	logic [word_width-1:0] value_q;
	logic [word_width-1:0] cluster_q;
	logic [word_width-1:0] dest_q;

	logic [addr_width-1:0] mem_addr;
	logic [addr_width-1:0] learn_addr;
	logic [addr_width-1:0] best_addr;
	logic [addr_width-1:0] policy_addr;
	logic mem_we;
	logic learn_we;
	logic [word_width-1:0] mem_wdata;
	logic [word_width-1:0] learn_wdata;
	logic [word_width-1:0] mem_rdata;

	logic [word_width-1:0] best_id;
	logic [word_width-1:0] best_value;
	logic [word_width-1:0] table_count;
	logic [word_width-1:0] hop_value;

	// one stage at a time, each done kicks off the next
	always_ff @(posedge clock) begin
		if (!nrst) begin
			stage <= stage_idle;
			busy <= 1'b0;
			start_learn <= 1'b0;
			start_best <= 1'b0;
			start_policy <= 1'b0;
			start_reward <= 1'b0;
		end else begin
			start_learn <= 1'b0;
			start_best <= 1'b0;
			start_policy <= 1'b0;
			start_reward <= 1'b0;
			case (stage)
				stage_idle: begin
					if (report_valid) begin
						busy <= 1'b1;
						start_learn <= 1'b1;
						stage <= stage_learn;
					end
				end
				stage_learn: begin
					if (done_learn) begin
						start_best <= 1'b1;
						stage <= stage_best;
					end
				end
				stage_best: begin
					if (done_best) begin
						start_policy <= 1'b1;
						stage <= stage_policy;
					end
				end
				stage_policy: begin
					if (done_policy) begin
						start_reward <= 1'b1;
						stage <= stage_reward;
					end
				end
				stage_reward: begin
					if (done_reward) begin
						busy <= 1'b0;
						stage <= stage_idle;
					end
				end
				default: stage <= stage_idle;
			endcase
		end
	end

	// reports arriving mid-round are dropped here
	always_ff @(posedge clock) begin
		if (stage == stage_idle && report_valid) begin
			src_q <= f_source_id;
			batt_q <= f_battery_stat;
			value_q <= f_value;
			cluster_q <= f_cluster_id;
			dest_q <= f_destination_id;
		end
	end

	// memory port steering, only the learning stage writes
	always_comb begin
		mem_addr = learn_addr;
		mem_we = 1'b0;
		mem_wdata = learn_wdata;
		case (stage)
			stage_learn: mem_we = learn_we;
			stage_best: mem_addr = best_addr;
			stage_policy: mem_addr = policy_addr;
			default: ;
		endcase
	end

	node_memory #(
		.mem_depth(mem_depth)
	) u_node_memory (
		.clock(clock),
		.addr(mem_addr),
		.we(mem_we),
		.wdata(mem_wdata),
		.rdata(mem_rdata)
	);

	learn_costs u_learn_costs (
		.clock(clock),
		.nrst(nrst),
		.start(start_learn),
		.source_id(src_q),
		.battery_stat(batt_q),
		.value(value_q),
		.cluster(cluster_q),
		.mem_addr(learn_addr),
		.mem_we(learn_we),
		.mem_wdata(learn_wdata),
		.mem_rdata(mem_rdata),
		.done(done_learn)
	);

	find_my_best #(
		.cluster_id(cluster_id)
	) u_find_my_best (
		.clock(clock),
		.nrst(nrst),
		.start(start_best),
		.mem_addr(best_addr),
		.mem_rdata(mem_rdata),
		.best_index(),
		.best_id(best_id),
		.best_value(best_value),
		.count(table_count),
		.done(done_best)
	);

	winner_policy #(
		.initial_epsilon(initial_epsilon),
		.epsilon_step(epsilon_step)
	) u_winner_policy (
		.clock(clock),
		.nrst(nrst),
		.start(start_policy),
		.best_id(best_id),
		.best_value(best_value),
		.count(table_count),
		.mem_addr(policy_addr),
		.mem_rdata(mem_rdata),
		.next_hop(next_hop),
		.hop_value(hop_value),
		.explored(explored),
		.done(done_policy)
	);

	compute_reward #(
		.node_id(node_id)
	) u_compute_reward (
		.clock(clock),
		.nrst(nrst),
		.start(start_reward),
		.destination_id(dest_q),
		.hop_value(hop_value),
		.reward(reward_out),
		.done(done_reward)
	);

	// a table write from the learning stage must never land outside its slot
	a_write_owner: assert property (@(posedge clock) disable iff (!nrst)
		learn_we |-> stage == stage_learn)
		else $error("qrouting_node: table write while stage is %s", stage.name());

endmodule

// ==== logic/qrouting_pkg.sv ====
package qrouting_pkg;

	// datapath and table memory sizes
	localparam int word_width = 16;
	localparam int addr_width = 8;
	localparam int max_neighbors = 16;

	// neighbor table, four parallel regions with one word per entry
	localparam logic [addr_width-1:0] neighbor_id_base = 8'h00;
	localparam logic [addr_width-1:0] q_value_base = 8'h10;
	localparam logic [addr_width-1:0] battery_base = 8'h20;
	localparam logic [addr_width-1:0] cluster_base = 8'h30;

	// number of valid entries in the regions above
	localparam logic [addr_width-1:0] neighbor_count_addr = 8'h40;

	// added on top of the next hop's cost
	localparam logic [word_width-1:0] hop_cost = 16'd1;

	// which stage owns the table memory
	typedef enum logic [2:0] {
		stage_idle = 3'd0,
		stage_learn = 3'd1,
		stage_best = 3'd2,
		stage_policy = 3'd3,
		stage_reward = 3'd4
	} stage_t;

endpackage

// ==== logic/winner_policy.sv ====
`timescale 1ns/1ps

module winner_policy #(
	parameter logic [3:0] initial_epsilon = 4'd6,
	parameter logic [3:0] epsilon_step = 4'd2
) (
	input logic clock,
	input logic nrst,
	input logic start,
	input logic [qrouting_pkg::word_width-1:0] best_id,
	input logic [qrouting_pkg::word_width-1:0] best_value,
	input logic [qrouting_pkg::word_width-1:0] count,
	output logic [qrouting_pkg::addr_width-1:0] mem_addr,
	input logic [qrouting_pkg::word_width-1:0] mem_rdata,
	output logic [qrouting_pkg::word_width-1:0] next_hop,
	output logic [qrouting_pkg::word_width-1:0] hop_value,
	output logic explored,
	output logic done
);
	import qrouting_pkg::*;

	localparam logic [2:0] s_idle = 3'd0;
	localparam logic [2:0] s_mod = 3'd1;
	localparam logic [2:0] s_rd_q = 3'd2;
	localparam logic [2:0] s_get_q = 3'd3;
	localparam logic [2:0] s_finish = 3'd4;

	logic [2:0] state;
	logic [7:0] lfsr;
	logic lfsr_fb;
	logic [3:0] epsilon;
	logic [3:0] eps_now;
	logic decay;
	logic explore;
	logic [3:0] rem;

	// x^8 + x^6 + x^5 + x^4 + 1 with period 255
	assign lfsr_fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

	always_ff @(posedge clock) begin
		if (!nrst) begin
			lfsr <= 8'h01;
		end else begin
			lfsr <= {lfsr[6:0], lfsr_fb};
		end
	end

	// decay of the previous round is applied when the next one starts,
	// so epsilon always matches the round that explored is reporting
	assign eps_now = !decay ? epsilon
		: (epsilon >= epsilon_step) ? epsilon - epsilon_step : 4'd0;
	assign explore = count != '0 && lfsr[3:0] < eps_now;

	// upper nibble picks the entry in at most 15 subtractions
	assign mem_addr = (state == s_rd_q ? q_value_base : neighbor_id_base) + addr_width'(rem);

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= s_idle;
			epsilon <= initial_epsilon;
			decay <= 1'b0;
			explored <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				s_idle: begin
					if (start) begin
						epsilon <= eps_now;
						decay <= 1'b1;
						explored <= explore;
						state <= explore ? s_mod : s_finish;
					end
				end
				s_mod: begin
					if (word_width'(rem) < count) begin
						state <= s_rd_q;
					end
				end
				s_rd_q: state <= s_get_q;
				s_get_q: state <= s_finish;
				s_finish: begin
					done <= 1'b1;
					state <= s_idle;
				end
				default: state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == s_idle && start) begin
			rem <= lfsr[7:4];
			if (!explore) begin
				next_hop <= best_id;
				hop_value <= best_value;
			end
		end
		if (state == s_mod && word_width'(rem) >= count) begin
			rem <= rem - count[3:0];
		end
		if (state == s_rd_q) begin
			next_hop <= mem_rdata;
		end
		if (state == s_get_q) begin
			hop_value <= mem_rdata;
		end
	end

	// once epsilon runs out it stays at zero and nothing explores
	a_no_explore_at_zero: assert property (@(posedge clock) disable iff (!nrst)
		(epsilon == '0) |-> !explored ##1 (epsilon == '0))
		else $error("winner_policy: explored at zero epsilon or epsilon left zero");

endmodule

// ==== qrouting_node.f ====
logic/qrouting_pkg.sv
logic/node_memory.sv
logic/learn_costs.sv
logic/find_my_best.sv
logic/winner_policy.sv
logic/compute_reward.sv
logic/qrouting_node.sv
verif/qrouting_node_tb.sv

// ==== verif/qrouting_node_tb.sv ====
`timescale 1ns/1ps

module qrouting_node_tb;
	import qrouting_pkg::*;

	localparam logic [word_width-1:0] own_id = 16'd3;
	localparam logic [word_width-1:0] own_cluster = 16'd1;
	localparam int clock_period = 20;
	// worst case for one round, all four stages on a full table
	localparam int round_cycles = 4 * max_neighbors + 20;
	// reports sent by all tests below
	localparam int total_reports = 43;
	localparam int watchdog_cycles = total_reports * (round_cycles + 10) + 200;

	logic clock;
	logic nrst;
	logic report_valid;
	logic [word_width-1:0] f_source_id;
	logic [word_width-1:0] f_battery_stat;
	logic [word_width-1:0] f_value;
	logic [word_width-1:0] f_cluster_id;
	logic [word_width-1:0] f_destination_id;
	logic busy;
	logic [word_width-1:0] next_hop;
	logic explored;
	logic [word_width-1:0] reward_out;
	logic done_reward;

	// reference neighbor table
	logic [word_width-1:0] model_id [max_neighbors];
	logic [word_width-1:0] model_cost [max_neighbors];
	logic [word_width-1:0] model_cluster [max_neighbors];
	int model_count = 0;

	logic [word_width-1:0] exp_best = '0;
	logic exp_is_dest = 1'b0;
	logic hop_known;
	logic [word_width-1:0] hop_cost_model;
	logic [word_width-1:0] exp_reward;

	int round_no = 0;
	int error_count = 0;
	int errors_at_test_start = 0;
	int tests_run = 0;
	int tests_failed = 0;
	string test_name;
	integer seed;

	qrouting_node #(
		.node_id(own_id),
		.cluster_id(own_cluster),
		.initial_epsilon(4'd6),
		.epsilon_step(4'd2)
	) u_qrouting_node (
		.clock(clock),
		.nrst(nrst),
		.report_valid(report_valid),
		.f_source_id(f_source_id),
		.f_battery_stat(f_battery_stat),
		.f_value(f_value),
		.f_cluster_id(f_cluster_id),
		.f_destination_id(f_destination_id),
		.busy(busy),
		.next_hop(next_hop),
		.explored(explored),
		.reward_out(reward_out),
		.done_reward(done_reward)
	);

	initial begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	initial begin
		#(watchdog_cycles * clock_period);
		$display("watchdog expired after %0d cycles, the run did not complete", watchdog_cycles);
		$display("Simulation FAILED");
		$finish;
	end

	// cost the model holds for whatever hop the DUT picked
	always_comb begin
		hop_known = 1'b0;
		hop_cost_model = '0;
		for (int k = 0; k < max_neighbors; k++) begin
			if (k < model_count && model_id[k] == next_hop) begin
				hop_known = 1'b1;
				hop_cost_model = model_cost[k];
			end
		end
		if (exp_is_dest) begin
			exp_reward = '0;
		end else if (hop_cost_model == 16'hffff) begin
			exp_reward = 16'hffff;
		end else begin
			exp_reward = hop_cost_model + 16'd1;
		end
	end

	a_idle_after_reset: assert property (@(posedge clock) $rose(nrst) |-> !busy && !done_reward)
		else begin
			error_count++;
			$display("[ERROR] busy got %h done_reward got %h expected 0 after reset",
				$sampled(busy), $sampled(done_reward));
		end

	a_busy_start: assert property (@(posedge clock) disable iff (!nrst)
		(report_valid && !busy) |=> busy)
		else begin
			error_count++;
			$display("[ERROR] busy got %h expected 1 after accepted report", $sampled(busy));
		end

	a_busy_hold: assert property (@(posedge clock) disable iff (!nrst)
		(busy && !done_reward) |=> busy)
		else begin
			error_count++;
			$display("[ERROR] busy got %h expected 1 before done_reward", $sampled(busy));
		end

	a_busy_end: assert property (@(posedge clock) disable iff (!nrst)
		done_reward |=> !busy)
		else begin
			error_count++;
			$display("[ERROR] busy got %h expected 0 after done_reward", $sampled(busy));
		end

	a_greedy_hop: assert property (@(posedge clock) disable iff (!nrst)
		(done_reward && !explored) |-> next_hop == exp_best)
		else begin
			error_count++;
			$display("[ERROR] round %0d next_hop got %h expected %h",
				round_no, $sampled(next_hop), exp_best);
		end

	a_explore_known: assert property (@(posedge clock) disable iff (!nrst)
		(done_reward && explored) |-> hop_known)
		else begin
			error_count++;
			$display("[ERROR] round %0d next_hop got %h, not an ID in the neighbor table",
				round_no, $sampled(next_hop));
		end

	a_late_explore: assert property (@(posedge clock) disable iff (!nrst)
		(done_reward && round_no > 3) |-> !explored)
		else begin
			error_count++;
			$display("[ERROR] round %0d explored got %h expected 0", round_no, $sampled(explored));
		end

	a_reward: assert property (@(posedge clock) disable iff (!nrst)
		done_reward |-> reward_out == exp_reward)
		else begin
			error_count++;
			$display("[ERROR] round %0d reward_out got %h expected %h",
				round_no, $sampled(reward_out), $sampled(exp_reward));
		end

	// update in place, or append while there is room
	function automatic void apply_to_model(
		input logic [word_width-1:0] src,
		input logic [word_width-1:0] cost,
		input logic [word_width-1:0] clus
	);
		int hit;
		hit = -1;
		for (int i = 0; i < model_count; i++) begin
			if (model_id[i] == src) begin
				hit = i;
			end
		end
		if (hit >= 0) begin
			model_cost[hit] = cost;
			model_cluster[hit] = clus;
		end else if (model_count < max_neighbors) begin
			model_id[model_count] = src;
			model_cost[model_count] = cost;
			model_cluster[model_count] = clus;
			model_count++;
		end
	endfunction

	// lowest cost in our cluster, else lowest overall, first index on a tie
	function automatic logic [word_width-1:0] model_best();
		int in_idx;
		int all_idx;
		in_idx = -1;
		all_idx = 0;
		for (int i = 0; i < model_count; i++) begin
			if (model_cluster[i] == own_cluster && (in_idx < 0 || model_cost[i] < model_cost[in_idx])) begin
				in_idx = i;
			end
			if (model_cost[i] < model_cost[all_idx]) begin
				all_idx = i;
			end
		end
		return (in_idx >= 0) ? model_id[in_idx] : model_id[all_idx];
	endfunction

	task automatic drive_report(
		input logic [word_width-1:0] src,
		input logic [word_width-1:0] cost,
		input logic [word_width-1:0] clus,
		input logic [word_width-1:0] dest
	);
		@(posedge clock);
		#2;
		f_source_id = src;
		f_battery_stat = 16'd200 - word_width'(round_no);
		f_value = cost;
		f_cluster_id = clus;
		f_destination_id = dest;
		report_valid = 1'b1;
		@(posedge clock);
		#2;
		report_valid = 1'b0;
	endtask

	task automatic start_report(
		input logic [word_width-1:0] src,
		input logic [word_width-1:0] cost,
		input logic [word_width-1:0] clus,
		input logic [word_width-1:0] dest
	);
		apply_to_model(src, cost, clus);
		round_no++;
		exp_best = model_best();
		exp_is_dest = (dest == own_id);
		drive_report(src, cost, clus, dest);
	endtask

	task automatic wait_for_round();
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (done_reward !== 1'b1 && cycles < round_cycles) begin
			@(negedge clock);
			cycles++;
		end
		if (done_reward !== 1'b1) begin
			error_count++;
			$display("round %0d never raised done_reward within %0d cycles, stuck in %s",
				round_no, cycles, u_qrouting_node.stage.name());
		end
		// let the checks sampled at done_reward run
		@(posedge clock);
		#1;
	endtask

	task automatic send_report(
		input logic [word_width-1:0] src,
		input logic [word_width-1:0] cost,
		input logic [word_width-1:0] clus,
		input logic [word_width-1:0] dest
	);
		start_report(src, cost, clus, dest);
		wait_for_round();
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		errors_at_test_start = error_count;
	endtask

	task automatic end_test();
		int errs;
		errs = error_count - errors_at_test_start;
		tests_run++;
		if (errs != 0) begin
			tests_failed++;
		end
		$display("test %-18s %s, %0d errors, %0d rounds so far, table holds %0d",
			test_name, (errs == 0) ? "ok" : "failed", errs, round_no, model_count);
	endtask

	initial begin
		logic [word_width-1:0] fill_cost;
		logic [word_width-1:0] fill_cluster;
		logic [word_width-1:0] fill_dest;
		seed = 32'h7783;
		nrst = 1'b0;
		report_valid = 1'b0;
		f_source_id = '0;
		f_battery_stat = '0;
		f_value = '0;
		f_cluster_id = '0;
		f_destination_id = '0;
		repeat (5) @(posedge clock);
		#2;
		nrst = 1'b1;

		// first report after reset starts from an empty table
		begin_test("learn_update");
		send_report(16'd10, 16'd50, own_cluster, 16'd7);
		send_report(16'd11, 16'd30, own_cluster, 16'd8);
		send_report(16'd11, 16'd90, own_cluster, 16'd8);
		send_report(16'd12, 16'd70, 16'd2, own_id);
		send_report(16'd10, 16'd40, own_cluster, 16'd9);
		end_test();

		// move everyone out of cluster 1, then a cost tie at 40
		begin_test("cluster_fallback");
		send_report(16'd10, 16'd40, 16'd2, 16'd7);
		send_report(16'd11, 16'd90, 16'd2, 16'd7);
		send_report(16'd13, 16'd40, 16'd0, 16'd7);
		send_report(16'd14, 16'd25, 16'd3, 16'd7);
		end_test();

		begin_test("cluster_tie");
		send_report(16'd15, 16'd60, own_cluster, 16'd8);
		send_report(16'd16, 16'd60, own_cluster, 16'd8);
		end_test();

		begin_test("fill_and_cap");
		while (model_count < max_neighbors) begin
			fill_cost = word_width'($random(seed)) & 16'h00ff;
			fill_cluster = word_width'($unsigned($random(seed)) % 3);
			fill_dest = word_width'($unsigned($random(seed)) % 6);
			send_report(16'd100 + word_width'(model_count), fill_cost, fill_cluster, fill_dest);
		end
		// table is full, these cheap in-cluster sources must be dropped
		for (int i = 0; i < 4; i++) begin
			send_report(16'd300 + word_width'(i), 16'd0, own_cluster, 16'd5);
		end
		end_test();

		// every entry goes to the top cost so the reward saturates
		begin_test("reward");
		for (int i = 0; i < max_neighbors; i++) begin
			send_report(model_id[i], 16'hffff, own_cluster, 16'd7);
		end
		send_report(model_id[0], 16'hffff, own_cluster, own_id);
		end_test();

		begin_test("busy_discipline");
		start_report(model_id[2], 16'd5, own_cluster, 16'd9);
		// would make entry 1 the cheapest and zero the reward if taken
		drive_report(model_id[1], 16'd0, own_cluster, own_id);
		wait_for_round();
		send_report(model_id[2], 16'd5, own_cluster, 16'd9);
		end_test();

		$display("tests run %0d, tests failed %0d, rounds %0d, errors %0d",
			tests_run, tests_failed, round_no, error_count);
		if (error_count == 0 && tests_failed == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule
